/* rtl/sim_ctrl_pkg.sv */
// Shared widths, word views, stream structs and event kinds, referenced by scoped name from every block
package sim_ctrl_pkg;

  // Width of a snooped write address
  parameter int unsigned ADDR_W = 32;

  // Width of a write data word and of a fetched instruction word
  parameter int unsigned DATA_W = 32;

  // Width of the free-running time counter and of every event timestamp
  parameter int unsigned TIME_W = 64;

  // One write data word, seen either as a console character or as an exit code
  // The console view only counts when the three upper bytes are zero
  typedef union packed {
    struct packed {
      logic [23:0] pad;
      logic [7:0]  chr;
    } console;
    logic [DATA_W-1:0] exit_code;
  } sim_word_u;

  // One write snooped from the tile's data port
  // Address and data arrive together, so a single strobe covers both
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    sim_word_u         data;
  } mem_wr_t;

  // One instruction word leaving the fetch stage
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] instr;
  } fetch_t;

  // Kind of an output event
  // The fourth code is never produced by the merger
  typedef enum logic [1:0] {
    EVT_CHAR = 2'd0,
    EVT_EXIT = 2'd1,
    EVT_SENT = 2'd2
  } evt_kind_e;

  // One timestamped event on the merged output stream
  // Payload holds the zero-extended character for EVT_CHAR,
  // the exit code for EVT_EXIT and zero for EVT_SENT
  // The stamp equals the time counter in the cycle the event is valid
  typedef struct packed {
    logic              valid;
    evt_kind_e         kind;
    logic [DATA_W-1:0] payload;
    logic [TIME_W-1:0] stamp;
  } event_t;

endpackage

/* rtl/wr_decode.sv */
// Write decoder that turns snooped tile writes into registered character and exit strobes
`timescale 1ns/1ps

module wr_decode #(
  // Address that the software writes characters to
  parameter logic [sim_ctrl_pkg::ADDR_W-1:0] CONSOLE_ADDR = 32'hFFFF_0004,
  // Address that the software writes its exit code to
  parameter logic [sim_ctrl_pkg::ADDR_W-1:0] EXIT_ADDR    = 32'hFFFF_0000
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  sim_ctrl_pkg::mem_wr_t             wr_i,
  output logic                              chr_vld_o,
  output logic [7:0]                        chr_o,
  output logic                              exit_vld_o,
  output logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code_o
);

  // Address matches, qualified by the write strobe
  logic con_sel;
  logic exit_sel;

  // Final decode results before the output register
  logic chr_hit;
  logic exit_hit;

  assign con_sel  = wr_i.valid && (wr_i.addr == CONSOLE_ADDR);
  assign exit_sel = wr_i.valid && (wr_i.addr == EXIT_ADDR);

  // A console write prints only a byte from 1 to 255
  // Any bit set in the upper three bytes makes it an ordinary store
  assign chr_hit = con_sel
                && (wr_i.data.console.pad == '0)
                && (wr_i.data.console.chr != '0);

  // An exit write of zero is a plain store and does not end the run
  assign exit_hit = exit_sel && (wr_i.data.exit_code != '0);

  // Strobes live for exactly one cycle, one cycle after the write is sampled
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      chr_vld_o  <= 1'b0;
      exit_vld_o <= 1'b0;
    end else begin
      chr_vld_o  <= chr_hit;
      exit_vld_o <= exit_hit;
    end
  end

  // Values are only loaded on a hit, so they stay stable between strobes
  always_ff @(posedge clk) begin
    if (chr_hit) begin
      chr_o <= wr_i.data.console.chr;
    end
    if (exit_hit) begin
      exit_code_o <= wr_i.data.exit_code;
    end
  end

  // Both strobes together would mean the two addresses overlap,
  // and the merger would silently drop the exit
  a_one_strobe : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(chr_vld_o && exit_vld_o)
  ) else $error("wr_decode raised character and exit strobes together");

endmodule

/* rtl/sentinel_mon.sv */
// Fetch monitor that raises a registered strobe for every fetched sentinel instruction
`timescale 1ns/1ps

module sentinel_mon #(
  // Instruction word that marks a point of interest in the program
  parameter logic [sim_ctrl_pkg::DATA_W-1:0] SENTINEL_WORD = 32'h5050_0013
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  sim_ctrl_pkg::fetch_t   fetch_i,
  output logic                   sent_vld_o
);

  // Match of the current fetch against the sentinel word
  logic sent_hit;

  // Only a valid fetch counts; the instruction bus may carry stale words
  assign sent_hit = fetch_i.valid && (fetch_i.instr == SENTINEL_WORD);

  // One strobe per matching fetch
  // Back-to-back sentinels give back-to-back strobes with no merging
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sent_vld_o <= 1'b0;
    end else begin
      sent_vld_o <= sent_hit;
    end
  end

  // Every strobe must trace back to a valid fetch in the cycle before
  a_sent_cause : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    sent_vld_o |-> $past(fetch_i.valid)
  ) else $error("sentinel_mon strobe without a preceding valid fetch");

endmodule

/* rtl/event_merge.sv */
// Event merger that timestamps detector strobes, orders them into one stream and tracks end of run
`timescale 1ns/1ps

module event_merge #(
  // Simulated nanoseconds added to the time counter each cycle
  parameter int unsigned TICK_NS = 10
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              chr_vld_i,
  input  logic [7:0]                        chr_i,
  input  logic                              exit_vld_i,
  input  logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code_i,
  input  logic                              sent_vld_i,
  output sim_ctrl_pkg::event_t              event_o,
  output logic                              eoc_o,
  output logic                              overflow_o,
  output logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code_o,
  output logic [sim_ctrl_pkg::TIME_W-1:0]   time_o
);

  // Time increment, widened once to the counter width
  localparam logic [sim_ctrl_pkg::TIME_W-1:0] TICK_INC =
    {{(sim_ctrl_pkg::TIME_W-32){1'b0}}, TICK_NS};

  // Time counter and its value in the next cycle
  logic [sim_ctrl_pkg::TIME_W-1:0] time_q;
  logic [sim_ctrl_pkg::TIME_W-1:0] time_nxt;

  // One-entry slot for a sentinel that lost against a write event
  logic slot_q;
  logic slot_nxt;
  logic sent_drop;

  // Event selected this cycle, registered into the output below
  logic                              wr_hit;
  logic                              emit_vld;
  sim_ctrl_pkg::evt_kind_e           emit_kind;
  logic [sim_ctrl_pkg::DATA_W-1:0]   emit_payload;

  // Output event register, with valid split from the payload fields
  logic                              evt_vld_q;
  sim_ctrl_pkg::evt_kind_e           evt_kind_q;
  logic [sim_ctrl_pkg::DATA_W-1:0]   evt_payload_q;
  logic [sim_ctrl_pkg::TIME_W-1:0]   evt_stamp_q;

  // Sticky end-of-run and overflow state
  logic                              eoc_q;
  logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code_q;
  logic                              overflow_q;

  assign time_nxt = time_q + TICK_INC;
  assign wr_hit   = chr_vld_i || exit_vld_i;

  // Writes win over sentinels; a losing sentinel parks in the slot
  // When no write fires, the slot drains and a new sentinel may take its place,
  // so it is only lost if a write fires while the slot is still occupied
  always_comb begin
    emit_vld     = 1'b0;
    emit_kind    = sim_ctrl_pkg::EVT_SENT;
    emit_payload = '0;
    slot_nxt     = slot_q;
    sent_drop    = 1'b0;
    if (chr_vld_i) begin
      emit_vld     = 1'b1;
      emit_kind    = sim_ctrl_pkg::EVT_CHAR;
      emit_payload = {{(sim_ctrl_pkg::DATA_W-8){1'b0}}, chr_i};
    end else if (exit_vld_i) begin
      emit_vld     = 1'b1;
      emit_kind    = sim_ctrl_pkg::EVT_EXIT;
      emit_payload = exit_code_i;
    end
    if (wr_hit) begin
      if (sent_vld_i) begin
        sent_drop = slot_q;
        slot_nxt  = 1'b1;
      end
    end else if (slot_q || sent_vld_i) begin
      // Sentinel events carry no payload
      emit_vld = 1'b1;
      slot_nxt = slot_q && sent_vld_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      time_q      <= '0;
      slot_q      <= 1'b0;
      evt_vld_q   <= 1'b0;
      eoc_q       <= 1'b0;
      exit_code_q <= '0;
      overflow_q  <= 1'b0;
    end else begin
      time_q    <= time_nxt;
      slot_q    <= slot_nxt;
      evt_vld_q <= emit_vld;
      // Only the first exit ends the run, later ones are just events
      if (exit_vld_i && !eoc_q) begin
        eoc_q       <= 1'b1;
        exit_code_q <= exit_code_i;
      end
      if (sent_drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // The stamp is the time seen while the event is on the output
  always_ff @(posedge clk) begin
    if (emit_vld) begin
      evt_kind_q    <= emit_kind;
      evt_payload_q <= emit_payload;
      evt_stamp_q   <= time_nxt;
    end
  end

  assign event_o.valid   = evt_vld_q;
  assign event_o.kind    = evt_kind_q;
  assign event_o.payload = evt_payload_q;
  assign event_o.stamp   = evt_stamp_q;
  assign eoc_o           = eoc_q;
  assign exit_code_o     = exit_code_q;
  assign overflow_o      = overflow_q;
  assign time_o          = time_q;

  // End of computation is final until the next reset
  a_eoc_sticky : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    eoc_o |=> eoc_o
  ) else $error("eoc_o fell outside reset");

  // A valid event always carries one of the three defined kinds
  a_kind_known : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    event_o.valid |-> (event_o.kind inside {sim_ctrl_pkg::EVT_CHAR,
                                            sim_ctrl_pkg::EVT_EXIT,
                                            sim_ctrl_pkg::EVT_SENT})
  ) else $error("event_o valid with an undefined kind");

endmodule

/* rtl/sim_ctrl_top.sv */
// Simulation-control top level that sets the addresses, sentinel and tick, and wires the blocks
`timescale 1ns/1ps

module sim_ctrl_top #(
  // Console character address seen on the tile's write port
  parameter logic [sim_ctrl_pkg::ADDR_W-1:0] CONSOLE_ADDR  = 32'hFFFF_0004,
  // Exit code address seen on the tile's write port
  parameter logic [sim_ctrl_pkg::ADDR_W-1:0] EXIT_ADDR     = 32'hFFFF_0000,
  // Instruction word reported as a sentinel event
  parameter logic [sim_ctrl_pkg::DATA_W-1:0] SENTINEL_WORD = 32'h5050_0013,
  // Simulated time per clock cycle in nanoseconds
  parameter int unsigned                     TICK_NS       = 10
) (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  sim_ctrl_pkg::mem_wr_t             wr_i,
  input  sim_ctrl_pkg::fetch_t              fetch_i,
  output sim_ctrl_pkg::event_t              event_o,
  output logic                              eoc_o,
  output logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code_o,
  output logic [sim_ctrl_pkg::TIME_W-1:0]   time_o,
  output logic                              overflow_o
);

  // Detector results, each a one-cycle strobe with its value
  logic                              chr_vld;
  logic [7:0]                        chr;
  logic                              exit_vld;
  logic [sim_ctrl_pkg::DATA_W-1:0]   exit_code;
  logic                              sent_vld;

  wr_decode #(
    .CONSOLE_ADDR ( CONSOLE_ADDR ),
    .EXIT_ADDR    ( EXIT_ADDR    )
  ) u_wr_decode (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n_i   ),
    .wr_i        ( wr_i      ),
    .chr_vld_o   ( chr_vld   ),
    .chr_o       ( chr       ),
    .exit_vld_o  ( exit_vld  ),
    .exit_code_o ( exit_code )
  );

  sentinel_mon #(
    .SENTINEL_WORD ( SENTINEL_WORD )
  ) u_sentinel_mon (
    .clk        ( clk      ),
    .rst_n_i    ( rst_n_i  ),
    .fetch_i    ( fetch_i  ),
    .sent_vld_o ( sent_vld )
  );

  // Adds the second cycle of latency and owns all top-level outputs
  event_merge #(
    .TICK_NS ( TICK_NS )
  ) u_event_merge (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .chr_vld_i   ( chr_vld     ),
    .chr_i       ( chr         ),
    .exit_vld_i  ( exit_vld    ),
    .exit_code_i ( exit_code   ),
    .sent_vld_i  ( sent_vld    ),
    .event_o     ( event_o     ),
    .eoc_o       ( eoc_o       ),
    .overflow_o  ( overflow_o  ),
    .exit_code_o ( exit_code_o ),
    .time_o      ( time_o      )
  );

endmodule

/* dv/tb_clk_gen.sv */
// Testbench clock and reset source; instantiate once in the testbench top to drive clk and rst_n
`timescale 1ns/1ps

module tb_clk_gen #(
  // Clock period in nanoseconds
  parameter int unsigned PERIOD_NS  = 10,
  // Rising edges seen while reset is held low
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // Release happens on a falling edge, away from the DUT's rising-edge logic
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* dv/tb_sim_ctrl.sv */
// Self-checking testbench for sim_ctrl_top; random writes and fetches checked against a cycle model
`timescale 1ns/1ps

module tb_sim_ctrl;

  localparam logic [31:0] CONSOLE_ADDR    = 32'hFFFF_0004;
  localparam logic [31:0] EXIT_ADDR       = 32'hFFFF_0000;
  localparam logic [31:0] SENTINEL_WORD   = 32'h5050_0013;
  localparam int unsigned TICK_NS         = 10;
  localparam int unsigned PERIOD_NS       = 10;
  localparam int          TEST_CYCLES     = 200;
  localparam int          DRAIN_CYCLES    = 4;
  localparam int          NUM_TESTS       = 6;
  // Every test runs its stimulus plus a drain, the rest is slack for reset
  localparam int          WATCHDOG_CYCLES = NUM_TESTS * (TEST_CYCLES + DRAIN_CYCLES) + 50;

  // What the detectors should report for one input edge
  typedef struct packed {
    logic        chr_vld;
    logic [7:0]  chr;
    logic        exit_vld;
    logic [31:0] code;
    logic        sent_vld;
  } det_t;

  logic                  clk;
  logic                  rst_n;
  sim_ctrl_pkg::mem_wr_t wr;
  sim_ctrl_pkg::fetch_t  fetch;
  sim_ctrl_pkg::event_t  evt;
  logic                  eoc;
  logic [31:0]           exit_code;
  logic [63:0]           time_now;
  logic                  overflow;

  // Model pipeline, oldest entry reaches the output in the current cycle
  det_t                  pipe_old;
  det_t                  pipe_new;
  // Model copies of the counter, the slot and the sticky flags
  logic [63:0]           m_time;
  logic                  m_slot;
  logic                  m_eoc;
  logic                  m_ovf;
  logic [31:0]           m_code;
  sim_ctrl_pkg::event_t  exp_evt;

  int checks;
  int errors;
  int test_errors;
  int test_events;
  int test_cycles;
  int tests_done;

  tb_clk_gen #(
    .PERIOD_NS  ( PERIOD_NS ),
    .RST_CYCLES ( 2         )
  ) u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  sim_ctrl_top #(
    .CONSOLE_ADDR  ( CONSOLE_ADDR  ),
    .EXIT_ADDR     ( EXIT_ADDR     ),
    .SENTINEL_WORD ( SENTINEL_WORD ),
    .TICK_NS       ( TICK_NS       )
  ) UUT (
    .clk         ( clk       ),
    .rst_n_i     ( rst_n     ),
    .wr_i        ( wr        ),
    .fetch_i     ( fetch     ),
    .event_o     ( evt       ),
    .eoc_o       ( eoc       ),
    .exit_code_o ( exit_code ),
    .time_o      ( time_now  ),
    .overflow_o  ( overflow  )
  );

  function automatic sim_ctrl_pkg::mem_wr_t make_wr(input logic v, input logic [31:0] addr,
                                                    input logic [31:0] word);
    sim_ctrl_pkg::mem_wr_t w;
    w.valid          = v;
    w.addr           = addr;
    w.data.exit_code = word;
    return w;
  endfunction

  function automatic sim_ctrl_pkg::fetch_t make_fetch(input logic v, input logic [31:0] instr);
    sim_ctrl_pkg::fetch_t f;
    f.valid = v;
    f.instr = instr;
    return f;
  endfunction

  // True with a probability of num out of den
  function automatic logic chance(input int unsigned num, input int unsigned den);
    return $urandom_range(den - 1, 0) < num;
  endfunction

  function automatic logic [31:0] rand_nonzero();
    logic [31:0] v;
    v = $urandom;
    if (v == 32'h0) begin
      v = 32'h1;
    end
    return v;
  endfunction

  // Console bytes print only from 1 to 255 with clear upper bytes; a zero exit code is a plain store
  function automatic det_t decode_inputs(input sim_ctrl_pkg::mem_wr_t w,
                                         input sim_ctrl_pkg::fetch_t f);
    det_t        d;
    logic [31:0] word;
    word       = w.data;
    d.chr_vld  = w.valid && (w.addr == CONSOLE_ADDR) && (word[31:8] == 24'h0)
                 && (word[7:0] != 8'h0);
    d.chr      = word[7:0];
    d.exit_vld = w.valid && (w.addr == EXIT_ADDR) && (word != 32'h0);
    d.code     = word;
    d.sent_vld = f.valid && (f.instr == SENTINEL_WORD);
    return d;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
      test_errors++;
    end
  endtask

  // One merger cycle: writes go first, a sentinel behind a write waits in the single slot
  task automatic advance_model();
    det_t d;
    d             = pipe_old;
    m_time        = m_time + 64'(TICK_NS);
    exp_evt       = '0;
    exp_evt.stamp = m_time;
    if (d.chr_vld || d.exit_vld) begin
      exp_evt.valid = 1'b1;
      if (d.chr_vld) begin
        exp_evt.kind    = sim_ctrl_pkg::EVT_CHAR;
        exp_evt.payload = {24'h0, d.chr};
      end else begin
        exp_evt.kind    = sim_ctrl_pkg::EVT_EXIT;
        exp_evt.payload = d.code;
        // Only the first exit ends the computation
        if (!m_eoc) begin
          m_eoc  = 1'b1;
          m_code = d.code;
        end
      end
      if (d.sent_vld) begin
        if (m_slot) begin
          m_ovf = 1'b1;
        end
        m_slot = 1'b1;
      end
    end else if (m_slot || d.sent_vld) begin
      // The parked sentinel leaves and a new one takes its place
      exp_evt.valid = 1'b1;
      exp_evt.kind  = sim_ctrl_pkg::EVT_SENT;
      m_slot        = m_slot && d.sent_vld;
    end
    if (exp_evt.valid) begin
      test_events++;
    end
  endtask

  task automatic compare_outputs();
    check_value("event_o.valid", 64'(evt.valid), 64'(exp_evt.valid));
    if (exp_evt.valid) begin
      check_value("event_o.kind", 64'(evt.kind), 64'(exp_evt.kind));
      check_value("event_o.payload", 64'(evt.payload), 64'(exp_evt.payload));
      check_value("event_o.stamp", evt.stamp, exp_evt.stamp);
    end
    check_value("time_o", time_now, m_time);
    check_value("eoc_o", 64'(eoc), 64'(m_eoc));
    check_value("overflow_o", 64'(overflow), 64'(m_ovf));
    if (m_eoc) begin
      check_value("exit_code_o", 64'(exit_code), 64'(m_code));
    end
  endtask

  // Outputs are checked on the falling edge, then the next inputs go out
  task automatic run_cycle(input sim_ctrl_pkg::mem_wr_t w, input sim_ctrl_pkg::fetch_t f);
    @(negedge clk);
    advance_model();
    compare_outputs();
    pipe_old = pipe_new;
    pipe_new = decode_inputs(w, f);
    wr       = w;
    fetch    = f;
    test_cycles++;
  endtask

  task automatic start_test();
    test_errors = 0;
    test_events = 0;
    test_cycles = 0;
  endtask

  // Idle cycles let the pipeline and the slot empty before the next test
  task automatic finish_test(input string name);
    repeat (DRAIN_CYCLES) run_cycle(make_wr(1'b0, 32'h0, 32'h0), make_fetch(1'b0, 32'h0));
    tests_done++;
    $display("test %-10s cycles=%0d events=%0d errors=%0d",
             name, test_cycles, test_events, test_errors);
  endtask

  initial begin
    sim_ctrl_pkg::mem_wr_t w_next;
    sim_ctrl_pkg::fetch_t  f_next;
    logic [31:0]           first_code;
    logic [31:0]           word;
    logic [31:0]           addr;
    int                    pick;
    wr         = '0;
    fetch      = '0;
    pipe_old   = '0;
    pipe_new   = '0;
    m_time     = '0;
    m_slot     = 1'b0;
    m_eoc      = 1'b0;
    m_ovf      = 1'b0;
    m_code     = '0;
    checks     = 0;
    errors     = 0;
    tests_done = 0;
    void'($urandom(32'hcbfb));

    // No rising edge has passed since release, so the counter still reads zero
    @(posedge rst_n);
    start_test();
    check_value("event_o.valid", 64'(evt.valid), 64'h0);
    check_value("eoc_o", 64'(eoc), 64'h0);
    check_value("overflow_o", 64'(overflow), 64'h0);
    check_value("time_o", time_now, 64'h0);
    finish_test("reset");

    start_test();
    for (int i = 0; i < TEST_CYCLES; i++) begin
      word = {24'h0, 8'($urandom_range(255, 1))};
      run_cycle(make_wr(chance(3, 4), CONSOLE_ADDR, word), make_fetch(1'b0, 32'h0));
    end
    finish_test("console");

    // Other addresses, zero bytes, dirty upper bytes, zero exits and idle strobes
    start_test();
    for (int i = 0; i < TEST_CYCLES; i++) begin
      pick = int'($urandom_range(4, 0));
      addr = $urandom;
      word = $urandom;
      case (pick)
        0: begin
          if (addr == CONSOLE_ADDR || addr == EXIT_ADDR) begin
            addr = 32'h0000_1000;
          end
        end
        1: begin
          addr = CONSOLE_ADDR;
          word = 32'h0;
        end
        2: begin
          addr       = CONSOLE_ADDR;
          word[31:8] = 24'($urandom_range(24'hFF_FFFF, 1));
        end
        3: begin
          addr = EXIT_ADDR;
          word = 32'h0;
        end
        default: begin
          addr = CONSOLE_ADDR;
          word = 32'h0000_0041;
        end
      endcase
      run_cycle(make_wr(pick != 4, addr, word), make_fetch(1'b0, 32'h0));
    end
    finish_test("ignored");

    // First exit lands at cycle 40, a different one is forced later
    start_test();
    first_code = $urandom_range(32'h7FFF_FFFF, 1);
    for (int i = 0; i < TEST_CYCLES; i++) begin
      pick = int'($urandom_range(7, 0));
      if (i == 40) begin
        w_next = make_wr(1'b1, EXIT_ADDR, first_code);
      end else if (i == 120) begin
        w_next = make_wr(1'b1, EXIT_ADDR, first_code + 32'h1);
      end else if (i > 40 && pick == 0) begin
        w_next = make_wr(1'b1, EXIT_ADDR, rand_nonzero());
      end else if (pick == 1) begin
        w_next = make_wr(1'b1, EXIT_ADDR, 32'h0);
      end else if (pick < 5) begin
        w_next = make_wr(1'b1, CONSOLE_ADDR, {24'h0, 8'($urandom_range(255, 1))});
      end else begin
        w_next = make_wr(1'b0, 32'h0, 32'h0);
      end
      run_cycle(w_next, make_fetch(1'b0, 32'h0));
    end
    check_value("eoc_o", 64'(eoc), 64'h1);
    check_value("exit_code_o", 64'(exit_code), 64'(first_code));
    finish_test("exit");

    start_test();
    for (int i = 0; i < TEST_CYCLES; i++) begin
      word = chance(1, 3) ? SENTINEL_WORD : rand_nonzero();
      run_cycle(make_wr(1'b0, 32'h0, 32'h0), make_fetch(chance(3, 4), word));
    end
    finish_test("sentinel");

    // Three back-to-back collisions park one sentinel and drop the next two
    start_test();
    for (int i = 0; i < TEST_CYCLES; i++) begin
      pick = int'($urandom_range(7, 0));
      if (i < 3 || (pick > 0 && pick < 4)) begin
        w_next = make_wr(1'b1, CONSOLE_ADDR, {24'h0, 8'($urandom_range(255, 1))});
      end else if (pick == 0) begin
        w_next = make_wr(1'b1, EXIT_ADDR, rand_nonzero());
      end else begin
        w_next = make_wr(1'b0, 32'h0, 32'h0);
      end
      f_next = make_fetch(i < 3 || chance(1, 2), SENTINEL_WORD);
      run_cycle(w_next, f_next);
    end
    check_value("overflow_o", 64'(overflow), 64'h1);
    finish_test("collision");

    $display("SUMMARY tests=%0d checks=%0d errors=%0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles before the tests finished",
             WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

/* src.f */
rtl/sim_ctrl_pkg.sv
rtl/wr_decode.sv
rtl/sentinel_mon.sv
rtl/event_merge.sv
rtl/sim_ctrl_top.sv
dv/tb_clk_gen.sv
dv/tb_sim_ctrl.sv

/* Makefile */
# Verilator build and run for the simulation-control testbench

VERILATOR ?= verilator
TOP       ?= tb_sim_ctrl
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
